// File: common/fpu_pkg.sv
package fpu_pkg;

  // major opcodes claimed from the core's instruction stream
  typedef enum logic [6:0] {
    FPU_OPCODE_LD  = 7'b0000111, // flw
    FPU_OPCODE_SW  = 7'b0100111, // fsw
    FPU_OPCODE_ARI = 7'b1010011  // op-fp group
  } fpu_opcode_t;

  // decoded operation, zero value means nothing claimed
  typedef enum logic [3:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE,
    OP_SGNJ,   // sign copied from rs2
    OP_SGNJN,  // sign inverted
    OP_SGNJX,  // sign xor
    OP_MIN,
    OP_MAX,
    OP_EQ,
    OP_LT,
    OP_LE,
    OP_MV_XW,  // fp reg -> int rd
    OP_MV_WX   // int rs1 -> fp reg
  } fpu_op_t;

  // funct7 values of the supported op-fp encodings (fmt = single)
  localparam logic [6:0] FUNCT7_SGNJ   = 7'b0010000;
  localparam logic [6:0] FUNCT7_MINMAX = 7'b0010100;
  localparam logic [6:0] FUNCT7_CMP    = 7'b1010000;
  localparam logic [6:0] FUNCT7_MV_XW  = 7'b1110000;
  localparam logic [6:0] FUNCT7_MV_WX  = 7'b1111000;

  // decode -> execute, registered at the claim edge
  typedef struct packed {
    logic               start;   // valid claimed instruction in execute
    fpu_op_t            op;
    logic [4:0]         rs1;     // fp source a
    logic [4:0]         rs2;     // fp source b, store data
    logic [4:0]         rd;      // fp or int destination
    logic signed [11:0] imm;     // i or s offset
    logic [31:0]        int_src; // core rs1 value taken with the insn
  } decode_execute_t;

  // execute -> result
  typedef struct packed {
    logic        f_wen; // write fp register file
    logic        x_wen; // write integer rd in the core
    logic [4:0]  rd;
    logic [31:0] data;
  } execute_result_t;

endpackage

// File: common/fpu_reg_if.sv
// register file read ports between execute and result
interface fpu_reg_if;

  logic [4:0]  rsel_s_0;  // read select a
  logic [4:0]  rsel_s_1;  // read select b
  logic [31:0] fdata_s_0; // read data a, combinational
  logic [31:0] fdata_s_1; // read data b, combinational

  // execute side picks the registers and takes the data
  modport exec (
    output rsel_s_0,
    output rsel_s_1,
    input  fdata_s_0,
    input  fdata_s_1
  );

  // result side owns the register file
  modport wb (
    input  rsel_s_0,
    input  rsel_s_1,
    output fdata_s_0,
    output fdata_s_1
  );

endinterface

// File: source/fpu_decode.sv
module fpu_decode import fpu_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            insn_valid,
  input  logic [31:0]     insn,
  input  logic [31:0]     int_rs1_data,
  output logic            insn_claim,
  output decode_execute_t idex
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [11:0] imm_i;
  logic [11:0] imm_s;
  logic [11:0] imm;
  fpu_op_t     op;

  // r, i and s fields
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];
  assign imm_i  = insn[31:20];
  assign imm_s  = {insn[31:25], insn[11:7]}; // store splits offset around rs2

  assign imm = (opcode == FPU_OPCODE_SW) ? imm_s : imm_i;

  always_comb begin
    op = OP_NONE;
    case (opcode)
      FPU_OPCODE_LD: if (funct3 == 3'b010) op = OP_LOAD;  // word width only
      FPU_OPCODE_SW: if (funct3 == 3'b010) op = OP_STORE;
      FPU_OPCODE_ARI: begin
        case (funct7)
          FUNCT7_SGNJ: begin
            case (funct3)
              3'b000:  op = OP_SGNJ;
              3'b001:  op = OP_SGNJN;
              3'b010:  op = OP_SGNJX;
              default: op = OP_NONE;
            endcase
          end
          FUNCT7_MINMAX: begin
            if (funct3 == 3'b000) op = OP_MIN;
            else if (funct3 == 3'b001) op = OP_MAX;
          end
          FUNCT7_CMP: begin
            case (funct3)
              3'b010:  op = OP_EQ;
              3'b001:  op = OP_LT;
              3'b000:  op = OP_LE;
              default: op = OP_NONE;
            endcase
          end
          // moves need rs2 = 0, funct3 = 1 here would be fclass
          FUNCT7_MV_XW: if (funct3 == 3'b000 && rs2 == 5'd0) op = OP_MV_XW;
          FUNCT7_MV_WX: if (funct3 == 3'b000 && rs2 == 5'd0) op = OP_MV_WX;
          default:      op = OP_NONE; // fadd and friends fall here
        endcase
      end
      default: op = OP_NONE;
    endcase
  end

  assign insn_claim = insn_valid && (op != OP_NONE);

  always_ff @(posedge CLK, negedge rst_n) begin
    if (!rst_n) begin
      idex <= '0;
    end else begin
      idex.start   <= insn_claim;
      idex.op      <= op;
      idex.rs1     <= rs1;
      idex.rs2     <= rs2;
      idex.rd      <= rd;
      idex.imm     <= imm;
      idex.int_src <= int_rs1_data; // core only holds it for the claim cycle
    end
  end

endmodule

// File: source/fpu_execute.sv
module fpu_execute import fpu_pkg::*; #(
  parameter int MEM_ADDR_W = 16
) (
  input  decode_execute_t        idex,
  fpu_reg_if.exec                regs,
  output logic                   mem_ren,
  output logic                   mem_wen,
  output logic [MEM_ADDR_W-1:0]  mem_addr,
  output logic [31:0]            mem_wdata,
  input  logic [31:0]            mem_rdata,
  output execute_result_t        exwb
);

  logic [31:0] fa;        // fp rs1
  logic [31:0] fb;        // fp rs2
  logic [31:0] addr_sum;
  logic        a_lt_b;    // total order, -0 below +0
  logic        both_zero;
  logic        feq;
  logic        flt;
  logic        fle;

  // operand read, result lands in the same cycle
  assign regs.rsel_s_0 = idex.rs1;
  assign regs.rsel_s_1 = idex.rs2;
  assign fa = regs.fdata_s_0;
  assign fb = regs.fdata_s_1;

  // effective address
  assign addr_sum  = idex.int_src + {{20{idex.imm[11]}}, idex.imm};
  assign mem_addr  = addr_sum[MEM_ADDR_W-1:0]; // upper bits dropped
  assign mem_ren   = idex.start && (idex.op == OP_LOAD);
  assign mem_wen   = idex.start && (idex.op == OP_STORE);
  assign mem_wdata = fb;

  // sign-magnitude ordering
  always_comb begin
    if (fa[31] != fb[31]) begin
      a_lt_b = fa[31];                // negative side is smaller
    end else if (fa[31]) begin
      a_lt_b = fa[30:0] > fb[30:0];   // both negative, larger magnitude is smaller
    end else begin
      a_lt_b = fa[30:0] < fb[30:0];
    end
  end

  // compares see +0 and -0 as equal
  assign both_zero = (fa[30:0] == 31'd0) && (fb[30:0] == 31'd0);
  assign feq       = (fa == fb) || both_zero;
  assign flt       = a_lt_b && !both_zero;
  assign fle       = flt || feq;

  always_comb begin
    exwb.f_wen = 1'b0;
    exwb.x_wen = 1'b0;
    exwb.rd    = idex.rd;
    exwb.data  = '0;
    case (idex.op)
      OP_LOAD: begin
        exwb.f_wen = 1'b1;
        exwb.data  = mem_rdata; // memory answers in this cycle
      end
      OP_SGNJ: begin
        exwb.f_wen = 1'b1;
        exwb.data  = {fb[31], fa[30:0]};
      end
      OP_SGNJN: begin
        exwb.f_wen = 1'b1;
        exwb.data  = {~fb[31], fa[30:0]};
      end
      OP_SGNJX: begin
        exwb.f_wen = 1'b1;
        exwb.data  = {fa[31] ^ fb[31], fa[30:0]};
      end
      OP_MIN: begin
        exwb.f_wen = 1'b1;
        exwb.data  = a_lt_b ? fa : fb;
      end
      OP_MAX: begin
        exwb.f_wen = 1'b1;
        exwb.data  = a_lt_b ? fb : fa;
      end
      OP_EQ: begin
        exwb.x_wen = 1'b1;
        exwb.data  = {31'd0, feq};
      end
      OP_LT: begin
        exwb.x_wen = 1'b1;
        exwb.data  = {31'd0, flt};
      end
      OP_LE: begin
        exwb.x_wen = 1'b1;
        exwb.data  = {31'd0, fle};
      end
      OP_MV_XW: begin
        exwb.x_wen = 1'b1;
        exwb.data  = fa;             // raw bits
      end
      OP_MV_WX: begin
        exwb.f_wen = 1'b1;
        exwb.data  = idex.int_src;
      end
      default: ;                     // store and none write nothing
    endcase
    // stale record when nothing was claimed
    if (!idex.start) begin
      exwb.f_wen = 1'b0;
      exwb.x_wen = 1'b0;
    end
  end

endmodule

// File: source/fpu_result.sv
module fpu_result import fpu_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  execute_result_t exwb,
  fpu_reg_if.wb           regs,
  output logic            int_wen,
  output logic [4:0]      int_rd,
  output logic [31:0]     int_data
);

  logic [31:0] fregs [32]; // f0..f31, f0 is a normal register

  // two async read ports
  assign regs.fdata_s_0 = fregs[regs.rsel_s_0];
  assign regs.fdata_s_1 = fregs[regs.rsel_s_1];

  // single write port, visible to the next execute cycle
  always_ff @(posedge CLK, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        fregs[i] <= '0;
      end
    end else if (exwb.f_wen) begin
      fregs[exwb.rd] <= exwb.data;
    end
  end

  // integer write-back strobe, one cycle wide
  always_ff @(posedge CLK, negedge rst_n) begin
    if (!rst_n) begin
      int_wen <= 1'b0;
    end else begin
      int_wen <= exwb.x_wen;
    end
  end

  // rd and data held until the next integer result
  always_ff @(posedge CLK) begin
    if (exwb.x_wen) begin
      int_rd   <= exwb.rd;
      int_data <= exwb.data;
    end
  end

endmodule

// File: source/fpu_ext.sv
module fpu_ext import fpu_pkg::*; #(
  parameter int MEM_ADDR_W = 16
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  // instruction stream from the core
  input  logic                  insn_valid,
  input  logic [31:0]           insn,
  input  logic [31:0]           int_rs1_data,
  output logic                  insn_claim,
  // data memory, fixed timing
  output logic                  mem_ren,
  output logic                  mem_wen,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic [31:0]           mem_wdata,
  input  logic [31:0]           mem_rdata,
  // integer register write-back
  output logic                  int_wen,
  output logic [4:0]            int_rd,
  output logic [31:0]           int_data
);

  decode_execute_t idex;  // claim cycle + 1
  execute_result_t exwb;  // into the write-back registers

  fpu_reg_if regs ();     // register file reads

  fpu_decode u_decode (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .int_rs1_data (int_rs1_data),
    .insn_claim   (insn_claim),
    .idex         (idex)
  );

  fpu_execute #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_execute (
    .idex      (idex),
    .regs      (regs.exec),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .exwb      (exwb)
  );

  fpu_result u_result (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .exwb     (exwb),
    .regs     (regs.wb),
    .int_wen  (int_wen),
    .int_rd   (int_rd),
    .int_data (int_data)
  );

endmodule

// File: dv/fpu_ext_checker.sv
// protocol checks on the top-level strobes, bound into fpu_ext
module fpu_ext_checker import fpu_pkg::*; (
  input logic        CLK,
  input logic        rst_n,
  input logic        insn_claim,
  input logic [31:0] insn,
  input logic        mem_ren,
  input logic        mem_wen,
  input logic        int_wen
);
  timeunit 1ns;
  timeprecision 100ps;

  logic int_claim; // claimed insn that ends in an integer rd

  // compares and fmv.x.w are the only op-fp encodings with an int result
  assign int_claim = insn_claim && (insn[6:0] == FPU_OPCODE_ARI) &&
                     ((insn[31:25] == FUNCT7_CMP) || (insn[31:25] == FUNCT7_MV_XW));

  mem_one_strobe: assert property (@(posedge CLK) !(mem_ren && mem_wen))
    else $error("mem_ren and mem_wen high in the same cycle");

  // async reset, strobes must be quiet the whole time
  reset_quiet: assert property (@(posedge CLK) !rst_n |-> (!mem_ren && !mem_wen && !int_wen))
    else $error("strobe active while rst_n low");

  int_wen_due: assert property (@(posedge CLK) disable iff (!rst_n)
    $past(int_claim, 2) |-> int_wen)
    else $error("int_wen missing two cycles after an integer-result claim");

  int_wen_cause: assert property (@(posedge CLK) disable iff (!rst_n)
    int_wen |-> $past(int_claim, 2))
    else $error("int_wen without an integer-result claim two cycles earlier");

endmodule

bind fpu_ext fpu_ext_checker u_checker (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .insn_claim (insn_claim),
  .insn       (insn),
  .mem_ren    (mem_ren),
  .mem_wen    (mem_wen),
  .int_wen    (int_wen)
);

// File: dv/fpu_ext_tb.sv
module fpu_ext_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_addr_w = 16;
  localparam int max_vec    = 64;
  // columns of one vector line
  localparam int col_gap    = 0;
  localparam int col_insn   = 1;
  localparam int col_rs1    = 2;
  localparam int col_rdata  = 3;
  localparam int col_claim  = 4;
  localparam int col_ren    = 5;
  localparam int col_wen    = 6;
  localparam int col_addr   = 7;
  localparam int col_wdata  = 8;
  localparam int col_iwen   = 9;
  localparam int col_ird    = 10;
  localparam int col_idata  = 11;
  localparam int num_cols   = 12;

  logic                  clk;
  logic                  rst_n;
  logic                  insn_valid;
  logic [31:0]           insn;
  logic [31:0]           int_rs1_data;
  logic                  insn_claim;
  logic                  mem_ren;
  logic                  mem_wen;
  logic [mem_addr_w-1:0] mem_addr;
  logic [31:0]           mem_wdata;
  logic [31:0]           mem_rdata;
  logic                  int_wen;
  logic [4:0]            int_rd;
  logic [31:0]           int_data;

  logic [31:0] vec [max_vec][num_cols]; // whole vector file
  int num_vec      = 0;
  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;
  int pipe [$];  // vector index per stage or -1 when idle

  fpu_ext #(
    .MEM_ADDR_W (mem_addr_w)
  ) fpu_ext_i (
    .CLK          (clk),
    .rst_n        (rst_n),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .int_rs1_data (int_rs1_data),
    .insn_claim   (insn_claim),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .int_wen      (int_wen),
    .int_rd       (int_rd),
    .int_data     (int_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // idle slots expect nothing
  function automatic logic [31:0] expected_at(input int idx, input int col);
    if (idx < 0) return '0;
    return vec[idx][col];
  endfunction

  task automatic load_vectors;
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [num_cols];
    fd = $fopen("dv/fpu_ext_vectors.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && num_vec < max_vec) begin
      n = $fgets(line, fd);
      // comment and blank lines give fewer fields
      if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                           col[0], col[1], col[2], col[3], col[4], col[5],
                           col[6], col[7], col[8], col[9], col[10], col[11]) == num_cols) begin
        for (int c = 0; c < num_cols; c++) vec[num_vec][c] = col[c];
        num_vec++;
      end
    end
    $fclose(fd);
  endtask

  // one clock with drive at the rising edge and checks at the falling edge
  task automatic run_cycle(input int idx);
    int          ex;
    int          wb;
    logic [31:0] exp_claim;
    logic [31:0] exp_ren;
    logic [31:0] exp_wen;
    logic [31:0] exp_iwen;
    @(posedge clk);
    pipe.push_front(idx);
    void'(pipe.pop_back());
    ex = pipe[1]; // claimed last cycle and now in execute
    wb = pipe[2]; // write-back visible now
    if (idx >= 0) begin
      insn_valid   <= 1'b1;
      insn         <= vec[idx][col_insn];
      int_rs1_data <= vec[idx][col_rs1];
    end else begin
      insn_valid   <= 1'b0;
      insn         <= $urandom; // junk that must not be claimed
      int_rs1_data <= $urandom;
    end
    mem_rdata <= (ex >= 0) ? vec[ex][col_rdata] : $urandom; // same-cycle load data
    @(negedge clk);
    exp_claim = expected_at(idx, col_claim);
    if (exp_claim == 1 && insn_claim !== 1'b1) begin
      other_errors++;
      $display("%0t: instruction %h of vector %0d was not claimed", $time, insn, idx);
    end else begin
      check_value("insn_claim", exp_claim, 32'(insn_claim));
    end
    exp_ren = expected_at(ex, col_ren);
    exp_wen = expected_at(ex, col_wen);
    check_value("mem_ren", exp_ren, 32'(mem_ren));
    check_value("mem_wen", exp_wen, 32'(mem_wen));
    if (exp_ren == 1 || exp_wen == 1) check_value("mem_addr", vec[ex][col_addr], 32'(mem_addr));
    if (exp_wen == 1) check_value("mem_wdata", vec[ex][col_wdata], mem_wdata);
    exp_iwen = expected_at(wb, col_iwen);
    if (exp_iwen == 0 && int_wen === 1'b1) begin
      other_errors++;
      $display("%0t: int_wen raised with no integer result due (int_rd %0d)", $time, int_rd);
    end else begin
      check_value("int_wen", exp_iwen, 32'(int_wen));
    end
    if (exp_iwen == 1) begin
      check_value("int_rd", vec[wb][col_ird], 32'(int_rd));
      check_value("int_data", vec[wb][col_idata], int_data);
    end
  endtask

  task automatic print_summary;
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
  endtask

  initial begin : main
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'h3dbb)); // seed once
    rst_n        = 1'b0;
    insn_valid   = 1'b0;
    insn         = '0;
    int_rs1_data = '0;
    mem_rdata    = '0;
    repeat (3) pipe.push_back(-1);
    load_vectors();
    cycle_limit = num_vec * 4 + 50; // worst case 3 cycles a vector plus reset and drain
    if (num_vec == 0) begin
      other_errors++;
      $display("no vectors could be read from dv/fpu_ext_vectors.txt");
      print_summary();
      $display("test failed");
      $finish;
    end else begin
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < num_vec; i++) begin
        if (vec[i][col_gap] != 0) repeat (int'($urandom % 3)) run_cycle(-1); // 0..2 idle
        run_cycle(i);
      end
      repeat (3) run_cycle(-1); // drain both stages
      print_summary();
      if (mismatches == 0 && other_errors == 0) $display("test passed");
      else $display("test failed");
      $finish;
    end
  end

  initial begin : watchdog
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    other_errors++;
    $display("timeout, run still going after %0d cycles", cycle_limit);
    print_summary();
    $display("test failed");
    $finish;
  end

endmodule

// File: dv/fpu_ext_vectors.txt
# gap insn int_rs1_data mem_rdata claim mem_ren mem_wen mem_addr mem_wdata int_wen int_rd int_data
# all hex; gap 1 allows 0-2 idle cycles before the line, gap 0 issues right after the previous
1 f00280d3 3fc00000 00000000 1 0 0 0000 00000000 0 00 00000000 # fmv.w.x f1 = 1.5
1 00132427 00001000 00000000 1 0 1 1008 3fc00000 0 00 00000000 # fsw f1, 8(x6)
1 ffc3a107 00012004 c0490fdb 1 1 0 2000 00000000 0 00 00000000 # flw f2, -4(x7), addr wraps
0 e0010553 00000000 00000000 1 0 0 0000 00000000 1 0a c0490fdb # fmv.x.w x10, f2 back to back
1 fe242827 00000100 00000000 1 0 1 00f0 c0490fdb 0 00 00000000 # fsw f2, -16(x8)
1 f00281d3 40490fdb 00000000 1 0 0 0000 00000000 0 00 00000000 # f3 = pi
1 f0028253 bf800000 00000000 1 0 0 0000 00000000 0 00 00000000 # f4 = -1.0
1 204182d3 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fsgnj f5, f3, f4
0 e00285d3 00000000 00000000 1 0 0 0000 00000000 1 0b c0490fdb # fmv.x.w x11, f5
1 20419353 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fsgnjn f6, f3, f4
1 e0030653 00000000 00000000 1 0 0 0000 00000000 1 0c 40490fdb # fmv.x.w x12, f6
1 204223d3 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fsgnjx f7, f4, f4
1 e00386d3 00000000 00000000 1 0 0 0000 00000000 1 0d 3f800000 # fmv.x.w x13, f7
1 f0028453 80000000 00000000 1 0 0 0000 00000000 0 00 00000000 # f8 = -0
1 f00284d3 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # f9 = +0
1 28848553 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fmin f10, f9, f8
1 e0050753 00000000 00000000 1 0 0 0000 00000000 1 0e 80000000 # fmv.x.w x14, f10
1 289415d3 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fmax f11, f8, f9
1 e00587d3 00000000 00000000 1 0 0 0000 00000000 1 0f 00000000 # fmv.x.w x15, f11
1 28418653 00000000 00000000 1 0 0 0000 00000000 0 00 00000000 # fmin f12, f3, f4
1 e0060853 00000000 00000000 1 0 0 0000 00000000 1 10 bf800000 # fmv.x.w x16, f12
1 a084a8d3 00000000 00000000 1 0 0 0000 00000000 1 11 00000001 # feq x17, f9, f8
1 a0941953 00000000 00000000 1 0 0 0000 00000000 1 12 00000000 # flt x18, f8, f9
1 a0940ad3 00000000 00000000 1 0 0 0000 00000000 1 15 00000001 # fle x21, f8, f9
1 a03209d3 00000000 00000000 1 0 0 0000 00000000 1 13 00000001 # fle x19, f4, f3
1 a0419a53 00000000 00000000 1 0 0 0000 00000000 1 14 00000000 # flt x20, f3, f4
1 a0321bd3 00000000 00000000 1 0 0 0000 00000000 1 17 00000001 # flt x23, f4, f3
1 a041ab53 00000000 00000000 1 0 0 0000 00000000 1 16 00000000 # feq x22, f3, f4
1 004180d3 00000000 00000000 0 0 0 0000 00000000 0 00 00000000 # fadd.s f1, f3, f4
1 00510093 00000000 00000000 0 0 0 0000 00000000 0 00 00000000 # addi x1, x2, 5
1 0003b087 00000000 00000000 0 0 0 0000 00000000 0 00 00000000 # fld f1, 0(x7)
1 00132027 0000abcd 00000000 1 0 1 abcd 3fc00000 0 00 00000000 # fsw f1, 0(x6), f1 kept

// File: sim.f
common/fpu_pkg.sv
common/fpu_reg_if.sv
source/fpu_decode.sv
source/fpu_execute.sv
source/fpu_result.sv
source/fpu_ext.sv
dv/fpu_ext_checker.sv
dv/fpu_ext_tb.sv

// File: Makefile
# Verilator build and run of the fpu_ext testbench

VERILATOR ?= verilator
TOP       ?= fpu_ext_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
